// File: filelist.f
+incdir+.
axi_lite_regs_pkg.sv
reg_wr_if.sv
axi_write_channel.sv
axi_read_channel.sv
reg_file.sv
axi_lite_regs_top.sv
tb_axi_lite_regs.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_axi_lite_regs --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
  exit 1
fi
exit 0

// File: tb_axi_lite_regs.sv
// Register block testbench
`timescale 1ns/1ps
`include "axi_lite_regs_consts.svh"

module tb_axi_lite_regs
  import axi_lite_regs_pkg::*;
();

  // AW and W orderings
  localparam int ORDER_BOTH     = 0;
  localparam int ORDER_AW_FIRST = 1;
  localparam int ORDER_W_FIRST  = 2;

  localparam int NUM_TESTS      = 6;
  localparam int TEST_BUDGET_NS = 2000;
  // Inputs change this long after the rising edge
  localparam int DRIVE_DELAY    = 10;

  logic  slv;
  logic  rst_n;
  addr_t awaddr;
  logic  awvalid;
  logic  awready;
  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;
  data_t irq_set;
  logic  irq;

  // Expected register contents
  data_t model [8];

  int errors;
  int checks;
  int tests_failed;
  int test_num;
  int errors_at_start;

  axi_lite_regs_top dut (
    .slv     (slv),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .irq_set (irq_set),
    .irq     (irq)
  );

  // 100 ns clock
  always #50 slv = ~slv;

  //////////////////////////////////////////////////////////////////////
  // Response hold checks
  //////////////////////////////////////////////////////////////////////

  // A stalled B response keeps valid and code
  assert property (@(posedge slv) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
  else begin
    $display("B response dropped or changed before bready at %0d ns", $time);
    errors++;
  end

  // A stalled R response keeps valid, data and code
  assert property (@(posedge slv) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
  else begin
    $display("R response dropped or changed before rready at %0d ns", $time);
    errors++;
  end

  // No new write accepted while B is pending
  assert property (@(posedge slv) disable iff (!rst_n)
    bvalid |-> !awready && !wready)
  else begin
    $display("AW or W ready while a B response is pending at %0d ns", $time);
    errors++;
  end

  // No new read accepted while R is pending
  assert property (@(posedge slv) disable iff (!rst_n)
    rvalid |-> !arready)
  else begin
    $display("AR ready while an R response is pending at %0d ns", $time);
    errors++;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp)
    else begin
      $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Enabled byte lanes of val replace those of old
  function automatic data_t apply_strobe(data_t old, data_t val, strb_t strb);
    data_t result;
    result = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = val[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic addr_t reg_addr(reg_idx_t idx);
    return {27'd0, idx, 2'b00};
  endfunction

  function automatic string reg_name(reg_idx_t idx);
    case (idx)
      3'd0:    return "CTRL";
      3'd1:    return "STATUS";
      3'd2:    return "DATA_TX";
      3'd3:    return "DATA_RX";
      3'd4:    return "IRQ_EN";
      3'd5:    return "IRQ_STAT";
      3'd6:    return "SCRATCH";
      default: return "VERSION";
    endcase
  endfunction

  // Ready delay for ordinary transfers
  function automatic int short_delay();
    return $urandom_range(1, 0);
  endfunction

  // One write, W and AW in the chosen order, bready after b_delay cycles
  task automatic write_reg(input addr_t addr, input data_t data, input strb_t strb,
                           input int order, input int b_delay, output resp_t resp);
    logic aw_done;
    logic w_done;
    logic aw_hit;
    logic w_hit;
    aw_done = 1'b0;
    w_done  = 1'b0;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = (order != ORDER_W_FIRST);
    wvalid  = (order != ORDER_AW_FIRST);
    while (!(aw_done && w_done)) begin
      // Handshake seen mid-cycle, transfer at the next edge
      @(negedge slv);
      aw_hit = awvalid && awready;
      w_hit  = wvalid && wready;
      @(posedge slv);
      #DRIVE_DELAY;
      // Payload is free to change once its half has transferred
      if (aw_hit) begin
        awvalid = 1'b0;
        aw_done = 1'b1;
        awaddr  = ~addr;
      end
      if (w_hit) begin
        wvalid  = 1'b0;
        w_done  = 1'b1;
        wdata   = ~data;
        wstrb   = ~strb;
      end
      // Second half goes out after the first has transferred
      if (aw_done && !w_done) begin
        wvalid = 1'b1;
      end
      if (w_done && !aw_done) begin
        awvalid = 1'b1;
      end
    end
    repeat (b_delay) begin
      @(posedge slv);
      #DRIVE_DELAY;
    end
    bready = 1'b1;
    do begin
      @(negedge slv);
    end while (!bvalid);
    resp = bresp;
    @(posedge slv);
    #DRIVE_DELAY;
    bready = 1'b0;
  endtask

  // One read, rready after r_delay cycles
  task automatic read_reg(input addr_t addr, input int r_delay,
                          output data_t data, output resp_t resp);
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      @(negedge slv);
    end while (!arready);
    @(posedge slv);
    #DRIVE_DELAY;
    arvalid = 1'b0;
    repeat (r_delay) begin
      @(posedge slv);
      #DRIVE_DELAY;
    end
    rready = 1'b1;
    do begin
      @(negedge slv);
    end while (!rvalid);
    data = rdata;
    resp = rresp;
    @(posedge slv);
    #DRIVE_DELAY;
    rready = 1'b0;
  endtask

  task automatic write_expect(input addr_t addr, input data_t data, input strb_t strb,
                              input int order, input int b_delay, input resp_t exp_resp,
                              input string name);
    resp_t resp;
    write_reg(addr, data, strb, order, b_delay, resp);
    check_value({name, " bresp"}, {30'd0, resp}, {30'd0, exp_resp});
  endtask

  task automatic read_expect(input addr_t addr, input data_t exp_data, input resp_t exp_resp,
                             input string name, input int r_delay);
    data_t data;
    resp_t resp;
    read_reg(addr, r_delay, data, resp);
    check_value({name, " rdata"}, data, exp_data);
    check_value({name, " rresp"}, {30'd0, resp}, {30'd0, exp_resp});
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d error(s)", test_num, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    #(NUM_TESTS * TEST_BUDGET_NS);
    $display("Watchdog expired, tests did not finish in %0d ns", NUM_TESTS * TEST_BUDGET_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    data_t    val;
    data_t    set_bits;
    data_t    clr;
    addr_t    bad_addr;
    reg_idx_t alias_idx;
    void'($urandom(32'h48b0));
    errors          = 0;
    checks          = 0;
    tests_failed    = 0;
    test_num        = 0;
    errors_at_start = 0;
    slv     = 1'b0;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    irq_set = '0;
    for (int i = 0; i < 8; i++) begin
      model[i] = '0;
    end
    model[`REG_VERSION] = `IP_VERSION;
    repeat (3) @(posedge slv);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    // Reset values
    check_value("awready", {31'd0, awready}, 32'd1);
    check_value("wready", {31'd0, wready}, 32'd1);
    check_value("arready", {31'd0, arready}, 32'd1);
    check_value("bvalid", {31'd0, bvalid}, 32'd0);
    check_value("rvalid", {31'd0, rvalid}, 32'd0);
    for (int i = 0; i < 8; i++) begin
      read_expect(reg_addr(reg_idx_t'(i)), model[i], `RESP_OKAY,
                  reg_name(reg_idx_t'(i)), short_delay());
    end
    check_value("irq", {31'd0, irq}, 32'd0);
    finish_test("reset values");

    // SCRATCH with each AW/W order
    for (int order = 0; order < 3; order++) begin
      val = $urandom;
      write_expect(reg_addr(`REG_SCRATCH), val, 4'hF, order, 0, `RESP_OKAY, "SCRATCH");
      model[`REG_SCRATCH] = val;
      read_expect(reg_addr(`REG_SCRATCH), model[`REG_SCRATCH], `RESP_OKAY, "SCRATCH",
                  short_delay());
    end
    finish_test("scratch write orders");

    // Partial strobes, then the STATUS mirror and RX loopback
    val = $urandom | 32'd1;
    write_expect(reg_addr(`REG_CTRL), val, 4'b0101, ORDER_AW_FIRST, 0, `RESP_OKAY, "CTRL");
    model[`REG_CTRL] = apply_strobe(model[`REG_CTRL], val, 4'b0101);
    val = $urandom;
    write_expect(reg_addr(`REG_IRQ_EN), val, 4'b1010, ORDER_W_FIRST, 0, `RESP_OKAY, "IRQ_EN");
    model[`REG_IRQ_EN] = apply_strobe(model[`REG_IRQ_EN], val, 4'b1010);
    val = $urandom;
    write_expect(reg_addr(`REG_DATA_TX), val, 4'hF, ORDER_BOTH, 0, `RESP_OKAY, "DATA_TX");
    model[`REG_DATA_TX] = val;
    model[`REG_STATUS]  = {31'd0, model[`REG_CTRL][0]};
    model[`REG_DATA_RX] = model[`REG_DATA_TX];
    read_expect(reg_addr(`REG_CTRL), model[`REG_CTRL], `RESP_OKAY, "CTRL", short_delay());
    read_expect(reg_addr(`REG_IRQ_EN), model[`REG_IRQ_EN], `RESP_OKAY, "IRQ_EN",
                short_delay());
    read_expect(reg_addr(`REG_STATUS), model[`REG_STATUS], `RESP_OKAY, "STATUS",
                short_delay());
    read_expect(reg_addr(`REG_DATA_RX), model[`REG_DATA_RX], `RESP_OKAY, "DATA_RX",
                short_delay());
    finish_test("strobes and mirrors");

    // Read-only registers keep their contents
    write_expect(reg_addr(`REG_STATUS), $urandom, 4'hF, ORDER_BOTH, 0, `RESP_OKAY, "STATUS");
    write_expect(reg_addr(`REG_DATA_RX), $urandom, 4'hF, ORDER_AW_FIRST, 0, `RESP_OKAY,
                 "DATA_RX");
    write_expect(reg_addr(`REG_VERSION), $urandom, 4'hF, ORDER_W_FIRST, 0, `RESP_OKAY,
                 "VERSION");
    read_expect(reg_addr(`REG_STATUS), model[`REG_STATUS], `RESP_OKAY, "STATUS",
                short_delay());
    read_expect(reg_addr(`REG_DATA_RX), model[`REG_DATA_RX], `RESP_OKAY, "DATA_RX",
                short_delay());
    read_expect(reg_addr(`REG_VERSION), model[`REG_VERSION], `RESP_OKAY, "VERSION",
                short_delay());
    finish_test("read-only registers");

    // Interrupt set, mask and W1C
    val = $urandom;
    write_expect(reg_addr(`REG_IRQ_EN), val, 4'hF, ORDER_BOTH, 0, `RESP_OKAY, "IRQ_EN");
    model[`REG_IRQ_EN] = val;
    set_bits = $urandom;
    irq_set  = set_bits;
    @(posedge slv);
    #DRIVE_DELAY;
    irq_set = '0;
    model[`REG_IRQ_STAT] = model[`REG_IRQ_STAT] | set_bits;
    check_value("irq", {31'd0, irq},
                {31'd0, |(model[`REG_IRQ_STAT] & model[`REG_IRQ_EN])});
    read_expect(reg_addr(`REG_IRQ_STAT), model[`REG_IRQ_STAT], `RESP_OKAY, "IRQ_STAT",
                short_delay());
    clr = $urandom;
    write_expect(reg_addr(`REG_IRQ_STAT), clr, 4'b0110, ORDER_BOTH, 0, `RESP_OKAY,
                 "IRQ_STAT");
    // Only ones in enabled lanes clear
    model[`REG_IRQ_STAT] = model[`REG_IRQ_STAT] & ~apply_strobe('0, clr, 4'b0110);
    read_expect(reg_addr(`REG_IRQ_STAT), model[`REG_IRQ_STAT], `RESP_OKAY, "IRQ_STAT",
                short_delay());
    check_value("irq", {31'd0, irq},
                {31'd0, |(model[`REG_IRQ_STAT] & model[`REG_IRQ_EN])});
    // Disable every pending bit, irq must drop while status stays set
    val = ~model[`REG_IRQ_STAT];
    write_expect(reg_addr(`REG_IRQ_EN), val, 4'hF, ORDER_BOTH, 0, `RESP_OKAY, "IRQ_EN");
    model[`REG_IRQ_EN] = val;
    check_value("irq", {31'd0, irq},
                {31'd0, |(model[`REG_IRQ_STAT] & model[`REG_IRQ_EN])});
    finish_test("interrupt status");

    // Out of range, slow bready and rready
    bad_addr  = `ADDR_MAX | ($urandom & 32'h0000_0FFC);
    alias_idx = bad_addr[4:2];
    write_expect(bad_addr, $urandom, 4'hF, ORDER_BOTH, $urandom_range(4, 1), `RESP_SLVERR,
                 "bad address");
    read_expect(bad_addr, `RD_POISON, `RESP_SLVERR, "bad address", $urandom_range(4, 1));
    read_expect(reg_addr(alias_idx), model[alias_idx], `RESP_OKAY, reg_name(alias_idx),
                short_delay());
    finish_test("out of range");

    $display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
             test_num, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: axi_lite_regs_top.sv
// AXI4-Lite register block top
`timescale 1ns/1ps

module axi_lite_regs_top
  import axi_lite_regs_pkg::*;
(
  input  logic  slv,
  input  logic  rst_n,
  // Write address
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  // Write data
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wvalid,
  output logic  wready,
  // Write response
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  // Read address
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  // Read data
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready,
  // Interrupt events in, request out
  input  data_t irq_set,
  output logic  irq
);

  // Write port from the write channel
  reg_wr_if wr_bus ();

  // Combinational read port
  reg_idx_t rd_idx;
  data_t    rd_data;

  axi_write_channel u_wr_ch (
    .slv     (slv),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .wr      (wr_bus)
  );

  axi_read_channel u_rd_ch (
    .slv     (slv),
    .rst_n   (rst_n),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rd_idx  (rd_idx),
    .rd_data (rd_data)
  );

  reg_file u_regs (
    .slv     (slv),
    .rst_n   (rst_n),
    .wr      (wr_bus),
    .rd_idx  (rd_idx),
    .rd_data (rd_data),
    .irq_set (irq_set),
    .irq     (irq)
  );

endmodule

// File: reg_file.sv
// Peripheral register file
`timescale 1ns/1ps
`include "axi_lite_regs_consts.svh"

module reg_file
  import axi_lite_regs_pkg::*;
(
  input  logic     slv,
  input  logic     rst_n,
  reg_wr_if.sink   wr,
  input  reg_idx_t rd_idx,
  output data_t    rd_data,
  input  data_t    irq_set,
  output logic     irq
);

  // Software-written registers
  data_t ctrl_q;
  data_t data_tx_q;
  data_t irq_en_q;
  data_t scratch_q;
  // Hardware-driven registers, STATUS holds only its enable bit
  logic  status_q;
  data_t data_rx_q;
  data_t irq_stat_q;

  // Strobes widened to bit lanes
  data_t wr_mask;
  // New value for byte-strobed registers
  data_t wr_merge;

  // Expand one enable per byte to a bit mask
  function automatic data_t lane_mask(strb_t strb);
    data_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[b*8 +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  assign wr_mask  = lane_mask(wr.strb);
  assign wr_merge = wr.data & wr_mask;

  //////////////////////////////////////////////////////////////////////
  // Register updates
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge slv) begin
    if (!rst_n) begin
      ctrl_q     <= '0;
      data_tx_q  <= '0;
      irq_en_q   <= '0;
      scratch_q  <= '0;
      status_q   <= 1'b0;
      data_rx_q  <= '0;
      irq_stat_q <= '0;
    end else begin
      // Byte-strobed read/write registers
      if (wr.en && wr.idx == `REG_CTRL) begin
        ctrl_q <= (ctrl_q & ~wr_mask) | wr_merge;
      end
      if (wr.en && wr.idx == `REG_DATA_TX) begin
        data_tx_q <= (data_tx_q & ~wr_mask) | wr_merge;
      end
      if (wr.en && wr.idx == `REG_IRQ_EN) begin
        irq_en_q <= (irq_en_q & ~wr_mask) | wr_merge;
      end
      if (wr.en && wr.idx == `REG_SCRATCH) begin
        scratch_q <= (scratch_q & ~wr_mask) | wr_merge;
      end
      // W1C on strobed lanes, new events take priority
      if (wr.en && wr.idx == `REG_IRQ_STAT) begin
        irq_stat_q <= (irq_stat_q & ~wr_merge) | irq_set;
      end else begin
        irq_stat_q <= irq_stat_q | irq_set;
      end
      // Enable mirror and TX to RX loopback, one cycle behind
      status_q  <= ctrl_q[0];
      data_rx_q <= data_tx_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux and interrupt
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (rd_idx)
      `REG_CTRL:     rd_data = ctrl_q;
      `REG_STATUS:   rd_data = {31'd0, status_q};
      `REG_DATA_TX:  rd_data = data_tx_q;
      `REG_DATA_RX:  rd_data = data_rx_q;
      `REG_IRQ_EN:   rd_data = irq_en_q;
      `REG_IRQ_STAT: rd_data = irq_stat_q;
      `REG_SCRATCH:  rd_data = scratch_q;
      default:       rd_data = `IP_VERSION;
    endcase
  end

  // Any pending status bit that is enabled
  assign irq = |(irq_stat_q & irq_en_q);

endmodule

// File: axi_read_channel.sv
// AXI4-Lite read channel
`timescale 1ns/1ps
`include "axi_lite_regs_consts.svh"

module axi_read_channel
  import axi_lite_regs_pkg::*;
(
  input  logic     slv,
  input  logic     rst_n,
  input  addr_t    araddr,
  input  logic     arvalid,
  output logic     arready,
  output data_t    rdata,
  output resp_t    rresp,
  output logic     rvalid,
  input  logic     rready,
  output reg_idx_t rd_idx,
  input  data_t    rd_data
);

  // One read outstanding at a time
  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  rd_state_e state_q;

  logic ar_fire;
  logic r_fire;
  logic ar_ok;

  assign ar_fire = arvalid & arready;
  assign r_fire  = rvalid & rready;

  assign arready = (state_q == RD_IDLE);
  assign rvalid  = (state_q == RD_RESP);

  // Register select straight from the bus
  assign rd_idx = araddr[4:2];
  assign ar_ok  = (araddr < `ADDR_MAX);

  //////////////////////////////////////////////////////////////////////
  // State and response code
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge slv) begin
    if (!rst_n) begin
      state_q <= RD_IDLE;
      rresp   <= `RESP_OKAY;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (ar_fire) begin
            state_q <= RD_RESP;
            rresp   <= ar_ok ? `RESP_OKAY : `RESP_SLVERR;
          end
        end
        default: begin
          // Held until the master takes it
          if (r_fire) begin
            state_q <= RD_IDLE;
            rresp   <= `RESP_OKAY;
          end
        end
      endcase
    end
  end

  // Read word, captured from the registers before this edge
  always_ff @(posedge slv) begin
    if (ar_fire) begin
      rdata <= ar_ok ? rd_data : `RD_POISON;
    end else if (r_fire) begin
      rdata <= '0;
    end
  end

endmodule

// File: axi_write_channel.sv
// AXI4-Lite write channel
`timescale 1ns/1ps
`include "axi_lite_regs_consts.svh"

module axi_write_channel
  import axi_lite_regs_pkg::*;
(
  input  logic     slv,
  input  logic     rst_n,
  input  addr_t    awaddr,
  input  logic     awvalid,
  output logic     awready,
  input  data_t    wdata,
  input  strb_t    wstrb,
  input  logic     wvalid,
  output logic     wready,
  output resp_t    bresp,
  output logic     bvalid,
  input  logic     bready,
  reg_wr_if.source wr
);

  // Which half of the write has arrived
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_GOT_ADDR,
    WR_GOT_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e state_q;
  wr_state_e state_d;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic pair_done;

  // Live address decode
  reg_idx_t aw_idx;
  logic     aw_ok;

  // Earlier operand, held until its partner arrives
  reg_idx_t aw_idx_q;
  logic     aw_ok_q;
  data_t    w_data_q;
  strb_t    w_strb_q;

  logic addr_ok;

  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;
  assign b_fire  = bvalid & bready;

  // Only the missing half is accepted, nothing while B is pending
  assign awready = (state_q == WR_IDLE) || (state_q == WR_GOT_DATA);
  assign wready  = (state_q == WR_IDLE) || (state_q == WR_GOT_ADDR);
  assign bvalid  = (state_q == WR_RESP);

  assign aw_idx = awaddr[4:2];
  assign aw_ok  = (awaddr < `ADDR_MAX);

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: begin
        if (aw_fire && w_fire) begin
          state_d = WR_RESP;
        end else if (aw_fire) begin
          state_d = WR_GOT_ADDR;
        end else if (w_fire) begin
          state_d = WR_GOT_DATA;
        end
      end
      WR_GOT_ADDR: begin
        if (w_fire) begin
          state_d = WR_RESP;
        end
      end
      WR_GOT_DATA: begin
        if (aw_fire) begin
          state_d = WR_RESP;
        end
      end
      default: begin
        if (b_fire) begin
          state_d = WR_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge slv) begin
    if (!rst_n) begin
      state_q <= WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address and data both present this cycle
  assign pair_done = (state_q != WR_RESP) && (state_d == WR_RESP);

  // Operand hold registers
  always_ff @(posedge slv) begin
    if (aw_fire) begin
      aw_idx_q <= aw_idx;
      aw_ok_q  <= aw_ok;
    end
    if (w_fire) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write issue and B response
  //////////////////////////////////////////////////////////////////////

  // Held address only when it came first, held data likewise
  assign addr_ok = (state_q == WR_GOT_ADDR) ? aw_ok_q : aw_ok;
  assign wr.idx  = (state_q == WR_GOT_ADDR) ? aw_idx_q : aw_idx;
  assign wr.data = (state_q == WR_GOT_DATA) ? w_data_q : wdata;
  assign wr.strb = (state_q == WR_GOT_DATA) ? w_strb_q : wstrb;
  assign wr.en   = pair_done & addr_ok;

  always_ff @(posedge slv) begin
    if (!rst_n) begin
      bresp <= `RESP_OKAY;
    end else if (pair_done) begin
      bresp <= addr_ok ? `RESP_OKAY : `RESP_SLVERR;
    end else if (b_fire) begin
      bresp <= `RESP_OKAY;
    end
  end

endmodule

// File: reg_wr_if.sv
// Register write port
`timescale 1ns/1ps

interface reg_wr_if
  import axi_lite_regs_pkg::*;
();

  // Single-cycle write strobe, in-range writes only
  logic     en;
  // Target register
  reg_idx_t idx;
  // Write word and byte enables
  data_t    data;
  strb_t    strb;

  // Write channel side
  modport source (
    output en, idx, data, strb
  );

  // Register file side
  modport sink (
    input en, idx, data, strb
  );

endinterface

// File: axi_lite_regs_pkg.sv
// Register block types
package axi_lite_regs_pkg;

  // Byte address on AW and AR
  typedef logic [31:0] addr_t;

  // Register contents and bus data word
  typedef logic [31:0] data_t;

  // One enable per byte lane of data_t
  typedef logic [3:0] strb_t;

  // Register select, address bits 4 to 2
  typedef logic [2:0] reg_idx_t;

  // B and R response code
  typedef logic [1:0] resp_t;

endpackage

// File: axi_lite_regs_consts.svh
// Register block constants
`ifndef AXI_LITE_REGS_CONSTS_SVH
`define AXI_LITE_REGS_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////////////////////////

// Register indices, address bits 4 to 2
`define REG_CTRL      3'd0
`define REG_STATUS    3'd1
`define REG_DATA_TX   3'd2
`define REG_DATA_RX   3'd3
`define REG_IRQ_EN    3'd4
`define REG_IRQ_STAT  3'd5
`define REG_SCRATCH   3'd6
`define REG_VERSION   3'd7

// First byte address past the register window
`define ADDR_MAX      32'd32

//////////////////////////////////////////////////////////////////////
// Bus responses and fixed words
//////////////////////////////////////////////////////////////////////

`define RESP_OKAY     2'b00
`define RESP_SLVERR   2'b10

// Returned on a read outside the window
`define RD_POISON     32'hDEAD_BEEF

// Contents of VERSION
`define IP_VERSION    32'h0001_0000

`endif
